// File: Makefile
TOP = quplsDecodeTb

.PHONY: all lint clean

# Build the testbench, run it and pass only if the pass message shows up
all:
	verilator --binary --assert -f quplsDecode.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert -f quplsDecode.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: common/quplsDecodePkg.sv
// Result types produced by the decode stage
// A specifier of zero in the result means that no register is used
// The immediate is always the full sign-extended width, zero when unused
package quplsDecodePkg;

`include "quplsDecode_config.svh"

	// ==================================================
	// Operation class and access size
	// ==================================================

	// Coarse class that steers the instruction to a unit
	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_RET,
		CLS_NONE
	} opClass_t;

	// Memory access width, byte up to hexi (128 bits)
	typedef enum logic [2:0] {
		SZ_BYTE,
		SZ_WYDE,
		SZ_TETRA,
		SZ_OCTA,
		SZ_HEXI,
		SZ_NONE
	} memSize_t;

	// ==================================================
	// Full decode result
	// ==================================================

	// Everything the next stage needs about one instruction
	typedef struct packed {
		quplsIsaPkg::regspec_t ra;
		quplsIsaPkg::regspec_t rb;
		quplsIsaPkg::regspec_t rc;
		quplsIsaPkg::regspec_t rt;
		logic [`QD_IMM_BITS-1:0] imm;
		opClass_t opClass;
		memSize_t memSize;
		logic illegal;
	} decoded_t;

endpackage

// File: common/quplsDecode_config.svh
// Build-time sizes for the decode stage
// The instruction word is fixed at 32 bits and holds one instruction
// The register file has 64 entries, so a specifier is 6 bits wide
// The return registers are four consecutive entries starting at the base
`ifndef QUPLS_DECODE_CONFIG_SVH
`define QUPLS_DECODE_CONFIG_SVH

// Width of one instruction word
`define QD_INSTR_BITS 32

// Width of a register specifier, 64 registers
`define QD_REG_BITS 6

// Width of the decoded immediate after sign extension
`define QD_IMM_BITS 64

// First of the four return registers selected by OP_RTD
`define QD_RTD_BASE 56

`endif

// File: common/quplsIsaPkg.sv
// Instruction set view of the front end
// Only the single-word formats are described, no compressed forms
// Bit 31 is reserved and ignored by the decoder
// Opcode values are local to this design and may be remapped freely
package quplsIsaPkg;

`include "quplsDecode_config.svh"

	localparam int OPCODE_BITS = 7;

	// Width of the immediate field held in bits 30:19
	localparam int IMM_FIELD_BITS = 12;

	// ==================================================
	// Basic field types
	// ==================================================

	// One register number
	typedef logic [`QD_REG_BITS-1:0] regspec_t;

	// The stores are kept contiguous, byte width first
	typedef enum logic [OPCODE_BITS-1:0] {
		OP_NOP  = 7'h0F,
		OP_ADD  = 7'h02,
		OP_ADDI = 7'h04,
		OP_LDO  = 7'h4B,
		OP_STB  = 7'h50,
		OP_STW  = 7'h51,
		OP_STT  = 7'h52,
		OP_STO  = 7'h53,
		OP_STX  = 7'h54,
		OP_RTD  = 7'h7C
	} opcode_t;

	// ==================================================
	// Instruction formats
	// ==================================================

	// Register format with four specifier fields
	// Target sits in 12:7, A in 18:13, B in 24:19, C in 30:25
	typedef struct packed {
		logic [`QD_INSTR_BITS-4*`QD_REG_BITS-OPCODE_BITS-1:0] resv;
		regspec_t rc;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t  opcode;
	} regFormat_t;

	// Immediate format, the immediate overlays the B and C fields
	typedef struct packed {
		logic [`QD_INSTR_BITS-IMM_FIELD_BITS-2*`QD_REG_BITS-OPCODE_BITS-1:0] resv;
		logic [IMM_FIELD_BITS-1:0] imm;
		regspec_t ra;
		regspec_t rt;
		opcode_t  opcode;
	} immFormat_t;

	// Both views share the opcode and the target and A fields
	typedef union packed {
		regFormat_t r;
		immFormat_t i;
	} instruction_t;

endpackage

// File: decode/decodeOperation.sv
// Operation decode: immediate, unit class, access size and illegal flag
// Purely combinational on the held instruction word
// The immediate is only produced for formats that carry one, else zero
// Any opcode not in the list is flagged illegal with class and size none
`timescale 1ns/1ps

`include "quplsDecode_config.svh"

module decodeOperation (
	input  quplsIsaPkg::instruction_t instr,
	output logic [`QD_IMM_BITS-1:0]   imm,
	output quplsDecodePkg::opClass_t  opClass,
	output quplsDecodePkg::memSize_t  memSize,
	output logic                      illegal
);

	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	// Sign-extended form of the 12-bit field in bits 30:19
	logic [`QD_IMM_BITS-1:0] immExt;

	assign immExt = {
		{(`QD_IMM_BITS-IMM_FIELD_BITS){instr.i.imm[IMM_FIELD_BITS-1]}},
		instr.i.imm
	};

	// ==================================================
	// Class, size and immediate by opcode
	// ==================================================
	always_comb
	begin
		imm     = '0;
		opClass = CLS_NONE;
		memSize = SZ_NONE;
		illegal = 1'b0;

		case (instr.i.opcode)
		OP_NOP:
			begin
				// Nothing to do, all outputs keep their idle values
				opClass = CLS_NONE;
			end
		OP_ADD:
			opClass = CLS_ALU;
		OP_ADDI:
			begin
				opClass = CLS_ALU;
				imm     = immExt;
			end
		OP_LDO:
			begin
				// The only load is a full octa load
				opClass = CLS_LOAD;
				memSize = SZ_OCTA;
				imm     = immExt;
			end
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
			begin
				opClass = CLS_STORE;
				imm     = immExt;
				// Store width follows the opcode order
				case (instr.i.opcode)
				OP_STB:  memSize = SZ_BYTE;
				OP_STW:  memSize = SZ_WYDE;
				OP_STT:  memSize = SZ_TETRA;
				OP_STO:  memSize = SZ_OCTA;
				default: memSize = SZ_HEXI;
				endcase
			end
		OP_RTD:
			begin
				// The immediate adjusts the stack on return
				opClass = CLS_RET;
				imm     = immExt;
			end
		default:
			illegal = 1'b1;
		endcase
	end

endmodule

// File: decode/decodeRegs.sv
// Register specifier decode for the four operand and target ports
// Purely combinational on the held instruction word
// A zero specifier means the port is unused or there is no write back
// Unknown opcodes fall back to the plain field mapping
`timescale 1ns/1ps

`include "quplsDecode_config.svh"

module decodeRegs (
	input  quplsIsaPkg::instruction_t instr,
	output quplsIsaPkg::regspec_t     ra,
	output quplsIsaPkg::regspec_t     rb,
	output quplsIsaPkg::regspec_t     rc,
	output quplsIsaPkg::regspec_t     rt
);

	import quplsIsaPkg::*;

	// Return register picked by the low two bits of the target field
	regspec_t rtdReg;

	assign rtdReg = regspec_t'(`QD_RTD_BASE) + regspec_t'(instr.r.rt[1:0]);

	// ==================================================
	// Specifier selection by opcode
	// ==================================================
	always_comb
	begin
		// Default mapping straight from the register format fields
		ra = instr.r.ra;
		rb = instr.r.rb;
		rc = instr.r.rc;
		rt = instr.r.rt;

		case (instr.r.opcode)
		OP_NOP:
			begin
				// A NOP reads and writes nothing
				ra = '0;
				rb = '0;
				rc = '0;
				rt = '0;
			end
		OP_ADDI, OP_LDO:
			begin
				// The immediate occupies the B field
				rb = '0;
			end
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
			begin
				// The target field names the store data register
				rc = instr.r.rt;
				rt = '0;
			end
		OP_RTD:
			begin
				// Return address comes from one of the return registers
				rc = rtdReg;
				rt = '0;
			end
		default:
			begin
				// Keep the default mapping, the illegal flag is raised elsewhere
				rt = instr.r.rt;
			end
		endcase
	end

endmodule

// File: logic/handshakeSlot.sv
// One-entry holding register with a four-phase port on each side
// The input side captures only while the slot is empty and outAck is low
// outReq is the full flag, so it is high exactly while a payload is held
// The payload register has no reset, only the control state does
`timescale 1ns/1ps

module handshakeSlot #(
	parameter type payloadT = logic [31:0]
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    inReq,
	output logic    inAck,
	input  payloadT inData,
	output logic    outReq,
	input  logic    outAck,
	output payloadT outData
);

	logic    full;
	logic    capture;
	payloadT slotData;

	// A new word is taken on a fresh request into an empty slot
	// Waiting for outAck low keeps the previous output phase from being cut short
	assign capture = inReq && !inAck && !full && !outAck;

	// ==================================================
	// Control state
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			inAck <= 1'b0;
			full  <= 1'b0;
		end
		else
		begin
			// Ack rises after the capture and holds until req is seen low
			if (capture)
				inAck <= 1'b1;
			else if (!inReq)
				inAck <= 1'b0;

			// The slot drains when the consumer acknowledges the held word
			if (capture)
				full <= 1'b1;
			else if (full && outAck)
				full <= 1'b0;
		end
	end

	// Payload only moves on a capture
	always_ff @(posedge clk)
	begin
		if (capture)
			slotData <= inData;
	end

	assign outReq  = full;
	assign outData = slotData;

endmodule

// File: logic/quplsDecode.sv
// Register and operation decode stage with four-phase ports on both sides
// Two words can be in flight, one in each holding slot
// Decode is combinational between the slots and adds no cycle of its own
// First result appears two edges after the request is sampled
`timescale 1ns/1ps

`include "quplsDecode_config.svh"

module quplsDecode (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      inReq,
	output logic                      inAck,
	input  quplsIsaPkg::instruction_t inInstr,
	output logic                      outReq,
	input  logic                      outAck,
	output quplsDecodePkg::decoded_t  outResult
);

	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	// Held instruction and its valid flag from the input slot
	instruction_t heldInstr;
	logic         heldValid;

	// Internal transfer between the slots
	logic xferAck;
	logic outSlotAck;

	// Decoder outputs
	regspec_t                ra;
	regspec_t                rb;
	regspec_t                rc;
	regspec_t                rt;
	logic [`QD_IMM_BITS-1:0] imm;
	opClass_t                opClass;
	memSize_t                memSize;
	logic                    illegal;
	decoded_t                decodedNext;

	// ==================================================
	// Input slot holds the raw instruction
	// ==================================================
	handshakeSlot #(
		.payloadT(instruction_t)
	) inSlot (
		.clk    (clk),
		.rstN   (rstN),
		.inReq  (inReq),
		.inAck  (inAck),
		.inData (inInstr),
		.outReq (heldValid),
		.outAck (xferAck),
		.outData(heldInstr)
	);

	decodeRegs regDecoder (
		.instr(heldInstr),
		.ra   (ra),
		.rb   (rb),
		.rc   (rc),
		.rt   (rt)
	);

	decodeOperation opDecoder (
		.instr  (heldInstr),
		.imm    (imm),
		.opClass(opClass),
		.memSize(memSize),
		.illegal(illegal)
	);

	// Gather the decoder fields into one result word
	always_comb
	begin
		decodedNext.ra      = ra;
		decodedNext.rb      = rb;
		decodedNext.rc      = rc;
		decodedNext.rt      = rt;
		decodedNext.imm     = imm;
		decodedNext.opClass = opClass;
		decodedNext.memSize = memSize;
		decodedNext.illegal = illegal;
	end

	// The output slot takes the word in the cycle it is free, which is the
	// same condition the slot uses for its own capture
	// Acking the input slot in that cycle frees it at the same edge
	assign xferAck = heldValid && !outSlotAck && !outReq && !outAck;

	// ==================================================
	// Output slot holds the decoded result
	// ==================================================
	handshakeSlot #(
		.payloadT(decoded_t)
	) outSlot (
		.clk    (clk),
		.rstN   (rstN),
		.inReq  (heldValid),
		.inAck  (outSlotAck),
		.inData (decodedNext),
		.outReq (outReq),
		.outAck (outAck),
		.outData(outResult)
	);

endmodule

// File: quplsDecode.f
+incdir+common
common/quplsIsaPkg.sv
common/quplsDecodePkg.sv
logic/handshakeSlot.sv
decode/decodeRegs.sv
decode/decodeOperation.sv
logic/quplsDecode.sv
sim/quplsDecode_sva.sv
sim/quplsDecodeTb.sv

// File: sim/quplsDecodeTb.sv
// Directed testbench for the decode stage
// Expected results are built from the decode rules in expectDecode
// Random fields use a fixed seed, so every run sends the same words
// Bit 31 of every word is kept clear since the stage ignores it
`timescale 1ns/1ps

`include "quplsDecode_config.svh"

module quplsDecodeTb;

	import quplsIsaPkg::*;
	import quplsDecodePkg::*;

	// Words sent by all tests together, this sizes the watchdog
	localparam int numInstr = 31;
	localparam int resetCycles = 10;

	logic         clk = 1'b0;
	logic         rstN;
	logic         inReq;
	logic         inAck;
	instruction_t inInstr;
	logic         outReq;
	logic         outAck;
	decoded_t     outResult;
	string        testName;

	quplsDecode UUT (
		.clk      (clk),
		.rstN     (rstN),
		.inReq    (inReq),
		.inAck    (inAck),
		.inInstr  (inInstr),
		.outReq   (outReq),
		.outAck   (outAck),
		.outResult(outResult)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ==================================================
	// Error handling and compare tasks
	// ==================================================
	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic reportMismatch(string field, string got, string exp);
		$display("FAILED at %0d ns: %s, %s is %s, expected %s",
			$time, testName, field, got, exp);
		abortRun();
	endtask

	task automatic checkRegs(string field, regspec_t got, regspec_t exp);
		if (got !== exp)
			reportMismatch(field, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic checkImm(logic [`QD_IMM_BITS-1:0] got, logic [`QD_IMM_BITS-1:0] exp);
		if (got !== exp)
			reportMismatch("imm", $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic checkClass(opClass_t gotC, opClass_t expC, memSize_t gotS, memSize_t expS);
		if (gotC !== expC)
			reportMismatch("class", gotC.name(), expC.name());
		if (gotS !== expS)
			reportMismatch("size", gotS.name(), expS.name());
	endtask

	task automatic checkIllegal(logic got, logic exp);
		if (got !== exp)
			reportMismatch("illegal", $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	// Handshake levels at a given point of a sequence
	task automatic checkLevel(string sig, logic got, logic exp);
		if (got !== exp)
			reportMismatch(sig, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic checkResult(decoded_t got, decoded_t exp);
		checkRegs("Ra", got.ra, exp.ra);
		checkRegs("Rb", got.rb, exp.rb);
		checkRegs("Rc", got.rc, exp.rc);
		checkRegs("Rt", got.rt, exp.rt);
		checkImm(got.imm, exp.imm);
		checkClass(got.opClass, exp.opClass, got.memSize, exp.memSize);
		checkIllegal(got.illegal, exp.illegal);
	endtask

	// ==================================================
	// Reference decode
	// ==================================================
	function automatic decoded_t expectDecode(logic [31:0] w);
		decoded_t e;
		// Fields straight from the word: target 12:7, A 18:13, B 24:19, C 30:25
		e.ra = w[18:13];
		e.rb = w[24:19];
		e.rc = w[30:25];
		e.rt = w[12:7];
		e.imm = '0;
		e.opClass = CLS_NONE;
		e.memSize = SZ_NONE;
		e.illegal = 1'b0;
		if (w[6:0] inside {OP_ADDI, OP_LDO, OP_STB, OP_STW, OP_STT, OP_STO, OP_STX, OP_RTD})
			e.imm = {{(`QD_IMM_BITS-12){w[30]}}, w[30:19]};
		case (w[6:0])
		OP_NOP:
			{e.ra, e.rb, e.rc, e.rt} = '0;
		OP_ADD:
			e.opClass = CLS_ALU;
		OP_ADDI:
			begin
				e.rb = '0;
				e.opClass = CLS_ALU;
			end
		OP_LDO:
			begin
				e.rb = '0;
				e.opClass = CLS_LOAD;
				e.memSize = SZ_OCTA;
			end
		OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
			begin
				e.rc = w[12:7];
				e.rt = '0;
				e.opClass = CLS_STORE;
			end
		OP_RTD:
			begin
				e.rc = regspec_t'(`QD_RTD_BASE + w[8:7]);
				e.rt = '0;
				e.opClass = CLS_RET;
			end
		default:
			e.illegal = 1'b1;
		endcase
		// Store width grows from byte to hexi
		case (w[6:0])
		OP_STB: e.memSize = SZ_BYTE;
		OP_STW: e.memSize = SZ_WYDE;
		OP_STT: e.memSize = SZ_TETRA;
		OP_STO: e.memSize = SZ_OCTA;
		OP_STX: e.memSize = SZ_HEXI;
		default: ;
		endcase
		return e;
	endfunction

	function automatic logic [31:0] randomWord(logic [6:0] op);
		logic [31:0] w;
		w = $urandom();
		w[31] = 1'b0;
		w[6:0] = op;
		return w;
	endfunction

	// ==================================================
	// Four-phase drivers, all changes on the falling edge
	// ==================================================
	task automatic sendInstr(logic [31:0] w);
		@(negedge clk);
		inInstr = instruction_t'(w);
		inReq = 1'b1;
		while (!inAck)
			@(negedge clk);
		inReq = 1'b0;
		while (inAck)
			@(negedge clk);
	endtask

	task automatic takeResult(output decoded_t res);
		@(negedge clk);
		while (!outReq)
			@(negedge clk);
		res = outResult;
		outAck = 1'b1;
		while (outReq)
			@(negedge clk);
		outAck = 1'b0;
	endtask

	task automatic runWord(logic [31:0] w);
		decoded_t got;
		sendInstr(w);
		takeResult(got);
		checkResult(got, expectDecode(w));
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic testResetState();
		logic [31:0] w;
		decoded_t got;
		testName = "reset state";
		w = randomWord(OP_ADDI);
		@(negedge clk);
		checkLevel("inAck", inAck, 1'b0);
		checkLevel("outReq", outReq, 1'b0);
		inInstr = instruction_t'(w);
		inReq = 1'b1;
		// One edge samples the request and inAck follows it
		@(negedge clk);
		checkLevel("inAck", inAck, 1'b1);
		checkLevel("outReq", outReq, 1'b0);
		inReq = 1'b0;
		// The next edge moves the word into the output slot
		@(negedge clk);
		checkLevel("outReq", outReq, 1'b1);
		takeResult(got);
		checkResult(got, expectDecode(w));
	endtask

	task automatic testAluDecode();
		testName = "ALU decode";
		for (int i = 0; i < 4; i++)
		begin
			runWord(randomWord(OP_ADD));
			runWord(randomWord(OP_ADDI));
		end
		runWord(randomWord(OP_NOP));
	endtask

	task automatic testStoreDecode();
		opcode_t stores[5] = '{OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
		logic [31:0] w;
		testName = "store decode";
		foreach (stores[i])
		begin
			// Once with a negative immediate, once with a positive one
			w = randomWord(stores[i]);
			w[30] = 1'b1;
			runWord(w);
			w[30] = 1'b0;
			runWord(w);
		end
	endtask

	task automatic testReturnDecode();
		logic [31:0] w;
		testName = "return decode";
		for (int k = 0; k < 4; k++)
		begin
			w = randomWord(OP_RTD);
			w[8:7] = k[1:0];
			runWord(w);
		end
		runWord(randomWord(OP_LDO));
	endtask

	task automatic testIllegalOpcode();
		logic [6:0] bad[3] = '{7'h00, 7'h33, 7'h7F};
		testName = "illegal opcode";
		foreach (bad[i])
			runWord(randomWord(bad[i]));
	endtask

	task automatic testBackPressure();
		logic [31:0] w[3];
		decoded_t got;
		testName = "back-pressure";
		w[0] = randomWord(OP_ADD);
		w[1] = randomWord(OP_LDO);
		w[2] = randomWord(OP_STT);
		// outAck stays low, so the first word parks in the output slot
		sendInstr(w[0]);
		sendInstr(w[1]);
		@(negedge clk);
		inInstr = instruction_t'(w[2]);
		inReq = 1'b1;
		repeat (8)
		begin
			@(negedge clk);
			checkLevel("inAck with both slots full", inAck, 1'b0);
		end
		takeResult(got);
		checkResult(got, expectDecode(w[0]));
		// Draining one result lets the third word in
		while (!inAck)
			@(negedge clk);
		inReq = 1'b0;
		while (inAck)
			@(negedge clk);
		for (int i = 1; i < 3; i++)
		begin
			takeResult(got);
			checkResult(got, expectDecode(w[i]));
		end
	endtask

	// ==================================================
	// Run control
	// ==================================================
	initial
	begin
		repeat (numInstr * 40 + resetCycles) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		abortRun();
	end

	always @(posedge clk)
	begin
		if (UUT.handshakeChecks.failCount != 0)
		begin
			$display("A handshake assertion fired");
			abortRun();
		end
	end

	initial
	begin
		void'($urandom(65088));
		rstN = 1'b0;
		inReq = 1'b0;
		inInstr = '0;
		outAck = 1'b0;
		testName = "reset";
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		testResetState();
		testAluDecode();
		testStoreDecode();
		testReturnDecode();
		testIllegalOpcode();
		testBackPressure();
		@(negedge clk);
		if (UUT.handshakeChecks.failCount == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("Handshake assertions fired during the run");
			abortRun();
		end
	end

endmodule

// File: sim/quplsDecode_sva.sv
// Four-phase handshake checks for the decode stage, bound to the top level
// The source and sink rules assume the testbench keeps to the protocol
// failCount is read by the testbench to end the run after an assertion fires
`timescale 1ns/1ps

module quplsDecodeSva (
	input logic                     clk,
	input logic                     rstN,
	input logic                     inReq,
	input logic                     inAck,
	input logic                     outReq,
	input logic                     outAck,
	input quplsDecodePkg::decoded_t outResult
);

	int failCount = 0;

	task automatic noteFailure(string what);
		failCount = failCount + 1;
		$error("Handshake rule broken: %s", what);
	endtask

	// ==================================================
	// Protocol rules
	// ==================================================

	// A request stays up until its acknowledge arrives
	inReqHeld: assert property (@(posedge clk) disable iff (!rstN)
		inReq && !inAck |=> inReq || inAck)
		else noteFailure("inReq dropped before inAck");
	outReqHeld: assert property (@(posedge clk) disable iff (!rstN) outReq && !outAck |=> outReq)
		else noteFailure("outReq dropped before outAck");

	// An acknowledge only answers a request that is present
	inAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN) $rose(inAck) |-> $past(inReq))
		else noteFailure("inAck rose without inReq");
	outAckNeedsReq: assert property (@(posedge clk) disable iff (!rstN) $rose(outAck) |-> outReq)
		else noteFailure("outAck rose without outReq");

	// The sink may sample the result at any point of the request phase
	resultStable: assert property (@(posedge clk) disable iff (!rstN)
		outReq && $past(outReq) |-> $stable(outResult))
		else noteFailure("outResult changed while outReq was high");

	// Reset leaves both ports idle
	resetIdle: assert property (@(posedge clk) !rstN |=> !inAck && !outReq)
		else noteFailure("inAck or outReq high after reset");

endmodule

bind quplsDecode quplsDecodeSva handshakeChecks (
	.clk      (clk),
	.rstN     (rstN),
	.inReq    (inReq),
	.inAck    (inAck),
	.outReq   (outReq),
	.outAck   (outAck),
	.outResult(outResult)
);
